// File: logic/cipher_ctrl.sv
/*
 * AES cipher round-sequencing controller
 * Redundant single-rail FSMs behind checked sparse handshake levels
 */

`include "cipher_ctrl_params.svh"

module cipher_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  cipher_ctrl_pkg::sp2v_e            in_valid_i,
  output cipher_ctrl_pkg::sp2v_e            in_ready_o,
  output cipher_ctrl_pkg::sp2v_e            out_valid_o,
  input  cipher_ctrl_pkg::sp2v_e            out_ready_i,

  input  cipher_ctrl_pkg::key_len_e         key_len_i,
  input  logic                              alert_fatal_i,
  output logic                              alert_o,

  output cipher_ctrl_pkg::sp2v_e            state_we_o,
  output cipher_ctrl_pkg::sp2v_e            key_expand_en_o,
  output cipher_ctrl_pkg::add_rk_sel_e      add_rk_sel_o,
  output logic [`CIPHER_CTRL_RND_CTR_W-1:0] key_expand_round_o
);

  localparam int unsigned W = `CIPHER_CTRL_SP2V_WIDTH;
  localparam logic [W-1:0] LOGIC_HIGH = `CIPHER_CTRL_SP2V_LOGIC_HIGH;

  logic [W-1:0] in_valid_sp, out_ready_sp;
  logic         in_valid_err, out_ready_err;
  logic         sp_enc_err;
  logic         rail_err;

  // Per-rail outputs
  logic [W-1:0] in_ready_mr, out_valid_mr, state_we_mr, key_expand_en_mr, alert_mr;
  cipher_ctrl_pkg::add_rk_sel_e [W-1:0]        add_rk_sel_mr;
  logic [W-1:0][`CIPHER_CTRL_RND_CTR_W-1:0]    rnd_ctr_mr;

  //////////////////////////////////////////////////////////////////////
  // Input checkers
  //////////////////////////////////////////////////////////////////////

  sp2v_buf_chk u_in_valid_chk (
    .sel_i  ( in_valid_i   ),
    .rail_o ( in_valid_sp  ),
    .err_o  ( in_valid_err )
  );

  sp2v_buf_chk u_out_ready_chk (
    .sel_i  ( out_ready_i   ),
    .rail_o ( out_ready_sp  ),
    .err_o  ( out_ready_err )
  );

  assign sp_enc_err = in_valid_err | out_ready_err;

  //////////////////////////////////////////////////////////////////////
  // Rails, one per sparse bit
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < W; i++) begin : gen_rail
    cipher_ctrl_rail #(
      .Polarity ( LOGIC_HIGH[i] )
    ) u_rail (
      .clk_i           ( clk_i               ),
      .rst_ni          ( rst_ni              ),
      .in_valid_i      ( in_valid_sp[i]      ),
      .in_ready_o      ( in_ready_mr[i]      ),
      .out_valid_o     ( out_valid_mr[i]     ),
      .out_ready_i     ( out_ready_sp[i]     ),
      .key_len_i       ( key_len_i           ),
      .sp_enc_err_i    ( sp_enc_err          ),
      .rail_err_i      ( rail_err            ), // Moore outputs, no loop
      .alert_fatal_i   ( alert_fatal_i       ),
      .state_we_o      ( state_we_mr[i]      ),
      .key_expand_en_o ( key_expand_en_mr[i] ),
      .add_rk_sel_o    ( add_rk_sel_mr[i]    ),
      .rnd_ctr_o       ( rnd_ctr_mr[i]       ),
      .alert_o         ( alert_mr[i]         )
    );
  end

  rail_combine u_combine (
    .in_ready_i      ( in_ready_mr        ),
    .out_valid_i     ( out_valid_mr       ),
    .state_we_i      ( state_we_mr        ),
    .key_expand_en_i ( key_expand_en_mr   ),
    .alert_i         ( alert_mr           ),
    .add_rk_sel_i    ( add_rk_sel_mr      ),
    .rnd_ctr_i       ( rnd_ctr_mr         ),
    .in_ready_o      ( in_ready_o         ),
    .out_valid_o     ( out_valid_o        ),
    .state_we_o      ( state_we_o         ),
    .key_expand_en_o ( key_expand_en_o    ),
    .add_rk_sel_o    ( add_rk_sel_o       ),
    .rnd_ctr_o       ( key_expand_round_o ),
    .alert_o         ( alert_o            ),
    .rail_err_o      ( rail_err           )
  );

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Rails agree, so every rebuilt level is legal
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW} &&
    out_valid_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW} &&
    state_we_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW} &&
    key_expand_en_o inside {cipher_ctrl_pkg::SP2V_HIGH, cipher_ctrl_pkg::SP2V_LOW});

  // No result leaves once an alert is up
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |-> out_valid_o == cipher_ctrl_pkg::SP2V_LOW);

  // Agreeing rails give an idle or one-hot selector
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !rail_err |-> $onehot0(add_rk_sel_o));

endmodule

// File: logic/cipher_ctrl_params.svh
/*
 * AES cipher control parameters
 * Sparse level width, rail polarity pattern and round counts
 */

`ifndef CIPHER_CTRL_PARAMS_SVH
`define CIPHER_CTRL_PARAMS_SVH

// Sparse two-valued word, one rail per bit
`define CIPHER_CTRL_SP2V_WIDTH 3

// Bit pattern of the high value, a 1 marks a positive rail
`define CIPHER_CTRL_SP2V_LOGIC_HIGH 3'b011

//////////////////////////////////////////////////////////////////////
// Round counts per key length
//////////////////////////////////////////////////////////////////////

`define CIPHER_CTRL_ROUNDS_128 10
`define CIPHER_CTRL_ROUNDS_192 12
`define CIPHER_CTRL_ROUNDS_256 14

// Holds 0 to 14
`define CIPHER_CTRL_RND_CTR_W 4

`endif

// File: logic/cipher_ctrl_pkg.sv
/*
 * AES cipher control package
 * Sparse handshake levels, key length and add-round-key selector types
 */

`include "cipher_ctrl_params.svh"

package cipher_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sparse two-valued level
  //////////////////////////////////////////////////////////////////////

  // Hamming distance 3 between the two legal values
  typedef enum logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Same word, read as a level for checking or as bits for the rails
  typedef union packed {
    sp2v_e                              enc;
    logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] rail;
  } sp2v_word_u;

  //////////////////////////////////////////////////////////////////////
  // Configuration and data path selectors
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  // All zero while no round is running
  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

endpackage

// File: logic/cipher_ctrl_rail.sv
/*
 * Single-rail AES round sequencer
 * One bit of every sparse level, with its own state and round counter
 */

`include "cipher_ctrl_params.svh"

module cipher_ctrl_rail #(
  parameter bit Polarity = 1'b1 // 1 = positive rail, 0 = inverted rail
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              in_valid_i,    // Rail bit
  output logic                              in_ready_o,    // Rail bit
  output logic                              out_valid_o,   // Rail bit
  input  logic                              out_ready_i,   // Rail bit

  input  cipher_ctrl_pkg::key_len_e         key_len_i,
  input  logic                              sp_enc_err_i,
  input  logic                              rail_err_i,
  input  logic                              alert_fatal_i,

  output logic                              state_we_o,    // Rail bit
  output logic                              key_expand_en_o, // Rail bit
  output cipher_ctrl_pkg::add_rk_sel_e      add_rk_sel_o,
  output logic [`CIPHER_CTRL_RND_CTR_W-1:0] rnd_ctr_o,
  output logic                              alert_o
);

  localparam int unsigned CTR_W = `CIPHER_CTRL_RND_CTR_W;

  // State encoding
  localparam logic [2:0] ST_IDLE   = 3'b000;
  localparam logic [2:0] ST_INIT   = 3'b011;
  localparam logic [2:0] ST_ROUND  = 3'b101;
  localparam logic [2:0] ST_FINISH = 3'b110;
  localparam logic [2:0] ST_ERROR  = 3'b111;

  logic [2:0]       state_d, state_q;
  logic [CTR_W-1:0] rnd_ctr_d, rnd_ctr_q;
  logic [CTR_W-1:0] nr_d, nr_q;       // Last round number
  logic [CTR_W-1:0] nr_sel;
  logic             key_len_ok;
  logic             in_valid, out_ready;
  logic             in_ready, out_valid, busy;

  // Negative rails see and drive inverted levels
  assign in_valid  = Polarity ? in_valid_i  : ~in_valid_i;
  assign out_ready = Polarity ? out_ready_i : ~out_ready_i;

  // Round limit from the key length
  always_comb begin
    key_len_ok = 1'b1;
    case (key_len_i)
      cipher_ctrl_pkg::AES_128: nr_sel = CTR_W'(`CIPHER_CTRL_ROUNDS_128);
      cipher_ctrl_pkg::AES_192: nr_sel = CTR_W'(`CIPHER_CTRL_ROUNDS_192);
      cipher_ctrl_pkg::AES_256: nr_sel = CTR_W'(`CIPHER_CTRL_ROUNDS_256);
      default: begin
        nr_sel     = '0;
        key_len_ok = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    nr_d      = nr_q;

    case (state_q)
      ST_IDLE: begin
        if (in_valid) begin
          nr_d      = nr_sel;
          rnd_ctr_d = '0;
          state_d   = key_len_ok ? ST_INIT : ST_ERROR;
        end
      end
      ST_INIT: begin
        rnd_ctr_d = CTR_W'(1);
        state_d   = ST_ROUND;
      end
      ST_ROUND: begin
        // Final round runs with the counter at nr
        if (rnd_ctr_q == nr_q) begin
          state_d = ST_FINISH;
        end else begin
          rnd_ctr_d = rnd_ctr_q + CTR_W'(1);
        end
      end
      ST_FINISH: begin
        if (out_ready) begin
          rnd_ctr_d = '0;
          state_d   = ST_IDLE;
        end
      end
      ST_ERROR: state_d = ST_ERROR; // Terminal
      default:  state_d = ST_ERROR;
    endcase

    // Errors win over any transition
    if (sp_enc_err_i || rail_err_i || alert_fatal_i) begin
      state_d = ST_ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      rnd_ctr_q <= '0;
      nr_q      <= '0;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      nr_q      <= nr_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Moore outputs
  //////////////////////////////////////////////////////////////////////

  assign in_ready  = (state_q == ST_IDLE);
  assign out_valid = (state_q == ST_FINISH);
  assign busy      = (state_q == ST_INIT) || (state_q == ST_ROUND);

  always_comb begin
    case (state_q)
      ST_INIT:  add_rk_sel_o = cipher_ctrl_pkg::ADD_RK_INIT;
      ST_ROUND: add_rk_sel_o = (rnd_ctr_q == nr_q) ? cipher_ctrl_pkg::ADD_RK_FINAL
                                                   : cipher_ctrl_pkg::ADD_RK_ROUND;
      default:  add_rk_sel_o = cipher_ctrl_pkg::add_rk_sel_e'(3'b000);
    endcase
  end

  assign in_ready_o      = Polarity ? in_ready  : ~in_ready;
  assign out_valid_o     = Polarity ? out_valid : ~out_valid;
  assign state_we_o      = Polarity ? busy      : ~busy;
  assign key_expand_en_o = Polarity ? busy      : ~busy;
  assign rnd_ctr_o       = rnd_ctr_q;
  assign alert_o         = (state_q == ST_ERROR);

  // Only reset leaves the error state
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == ST_ERROR |=> state_q == ST_ERROR);

endmodule

// File: logic/rail_combine.sv
/*
 * Rail combiner
 * Rebuilds sparse levels from rail bits, ORs the multi-bit outputs
 * and flags any rail that disagrees with the combined value
 */

`include "cipher_ctrl_params.svh"

module rail_combine (
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] in_ready_i,
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] out_valid_i,
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] state_we_i,
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] key_expand_en_i,
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] alert_i,
  input  cipher_ctrl_pkg::add_rk_sel_e [`CIPHER_CTRL_SP2V_WIDTH-1:0] add_rk_sel_i,
  input  logic [`CIPHER_CTRL_SP2V_WIDTH-1:0][`CIPHER_CTRL_RND_CTR_W-1:0] rnd_ctr_i,

  output cipher_ctrl_pkg::sp2v_e             in_ready_o,
  output cipher_ctrl_pkg::sp2v_e             out_valid_o,
  output cipher_ctrl_pkg::sp2v_e             state_we_o,
  output cipher_ctrl_pkg::sp2v_e             key_expand_en_o,
  output cipher_ctrl_pkg::add_rk_sel_e       add_rk_sel_o,
  output logic [`CIPHER_CTRL_RND_CTR_W-1:0]  rnd_ctr_o,
  output logic                               alert_o,
  output logic                               rail_err_o
);

  logic [2:0]                        sel_or;
  logic [`CIPHER_CTRL_RND_CTR_W-1:0] ctr_or;

  // Rail bits already carry the right polarity
  assign in_ready_o      = cipher_ctrl_pkg::sp2v_e'(in_ready_i);
  assign out_valid_o     = cipher_ctrl_pkg::sp2v_e'(out_valid_i);
  assign state_we_o      = cipher_ctrl_pkg::sp2v_e'(state_we_i);
  assign key_expand_en_o = cipher_ctrl_pkg::sp2v_e'(key_expand_en_i);

  assign alert_o = |alert_i; // One rail is enough

  //////////////////////////////////////////////////////////////////////
  // OR-combine and compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_or     = '0;
    ctr_or     = '0;
    rail_err_o = 1'b0;
    for (int i = 0; i < `CIPHER_CTRL_SP2V_WIDTH; i++) begin
      sel_or = sel_or | add_rk_sel_i[i];
      ctr_or = ctr_or | rnd_ctr_i[i];
    end
    // A legal-looking OR result can still hide a stuck rail
    for (int i = 0; i < `CIPHER_CTRL_SP2V_WIDTH; i++) begin
      if (add_rk_sel_i[i] != sel_or || rnd_ctr_i[i] != ctr_or) begin
        rail_err_o = 1'b1;
      end
    end
  end

  assign add_rk_sel_o = cipher_ctrl_pkg::add_rk_sel_e'(sel_or);
  assign rnd_ctr_o    = ctr_or;

endmodule

// File: logic/sp2v_buf_chk.sv
/*
 * Sparse level buffer and checker
 * Splits one sparse word into rail bits and flags illegal encodings
 */

`include "cipher_ctrl_params.svh"

module sp2v_buf_chk (
  input  cipher_ctrl_pkg::sp2v_e              sel_i,
  output logic [`CIPHER_CTRL_SP2V_WIDTH-1:0] rail_o,
  output logic                               err_o
);

  cipher_ctrl_pkg::sp2v_word_u word;

  assign word = cipher_ctrl_pkg::sp2v_word_u'(sel_i);

  // Bit i goes to rail i, polarity is handled inside the rail
  assign rail_o = word.rail;

  // Only the two legal levels pass
  always_comb begin
    case (word.enc)
      cipher_ctrl_pkg::SP2V_HIGH: err_o = 1'b0;
      cipher_ctrl_pkg::SP2V_LOW:  err_o = 1'b0;
      default:                    err_o = 1'b1; // Any other pattern incl. X
    endcase
  end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cipher_ctrl_tb -o cipher_ctrl_sim
./obj_dir/cipher_ctrl_sim > sim.log
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: testbench/cipher_ctrl_tb.sv
/*
 * Testbench for the AES round-sequencing controller
 * Table-driven round sequences, back-pressure and terminal error cases
 */

`include "cipher_ctrl_params.svh"

module cipher_ctrl_tb;

  localparam int RND_W        = `CIPHER_CTRL_RND_CTR_W;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_STALL    = 7;
  localparam int HOLD_CYCLES  = 4;  // Error state observed with legal inputs
  localparam int FATAL_AT     = 4;  // Round cycle that sees the fatal alert
  localparam int NUM_ROWS     = 8;
  localparam int TIMEOUT      = NUM_ROWS * (14 + 2 + MAX_STALL + 10)
                                + RESET_CYCLES * (NUM_ROWS + 1);

  // Test kinds
  localparam int T_NORMAL = 0;
  localparam int T_BAD_SP = 1;
  localparam int T_FATAL  = 2;
  localparam int T_BAD_KL = 3;

  localparam cipher_ctrl_pkg::add_rk_sel_e SEL_IDLE = cipher_ctrl_pkg::add_rk_sel_e'(3'b000);

  typedef struct {
    int         kind;
    logic [2:0] key_len;
    int         stall;
    logic [2:0] bad_word;
    int         nr;
  } row_t;

  logic                         clk_i;
  logic                         rst_ni;
  cipher_ctrl_pkg::sp2v_e       in_valid_i, out_ready_i;
  cipher_ctrl_pkg::key_len_e    key_len_i;
  logic                         alert_fatal_i;
  cipher_ctrl_pkg::sp2v_e       in_ready_o, out_valid_o, state_we_o, key_expand_en_o;
  cipher_ctrl_pkg::add_rk_sel_e add_rk_sel_o;
  logic [RND_W-1:0]             key_expand_round_o;
  logic                         alert_o;

  row_t   tbl [NUM_ROWS];
  integer seed;
  int     n_checks, n_errors, test_errors, n_failed_tests, cycle_cnt;

  cipher_ctrl dut (
    .clk_i              ( clk_i              ),
    .rst_ni             ( rst_ni             ),
    .in_valid_i         ( in_valid_i         ),
    .in_ready_o         ( in_ready_o         ),
    .out_valid_o        ( out_valid_o        ),
    .out_ready_i        ( out_ready_i        ),
    .key_len_i          ( key_len_i          ),
    .alert_fatal_i      ( alert_fatal_i      ),
    .alert_o            ( alert_o            ),
    .state_we_o         ( state_we_o         ),
    .key_expand_en_o    ( key_expand_en_o    ),
    .add_rk_sel_o       ( add_rk_sel_o       ),
    .key_expand_round_o ( key_expand_round_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("Timeout: simulation ran past %0d cycles without finishing", TIMEOUT);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_sp2v(input string name, input cipher_ctrl_pkg::sp2v_e act,
                            input cipher_ctrl_pkg::sp2v_e exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_sel(input string name, input cipher_ctrl_pkg::add_rk_sel_e act,
                           input cipher_ctrl_pkg::add_rk_sel_e exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_rnd(input string name, input logic [RND_W-1:0] act,
                           input logic [RND_W-1:0] exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      test_errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h at %0t", name, act, exp, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequences, each starts and ends right after a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic expect_idle();
    check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_HIGH);
    check_sp2v("out_valid_o", out_valid_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sp2v("state_we_o", state_we_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sp2v("key_expand_en_o", key_expand_en_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sel("add_rk_sel_o", add_rk_sel_o, SEL_IDLE);
    check_rnd("key_expand_round_o", key_expand_round_o, '0);
    check_bit("alert_o", alert_o, 1'b0);
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    expect_idle();
  endtask

  task automatic accept_block(input logic [2:0] klen);
    check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_HIGH);
    in_valid_i = cipher_ctrl_pkg::SP2V_HIGH;
    key_len_i  = cipher_ctrl_pkg::key_len_e'(klen);
  endtask

  task automatic run_rounds(input logic [2:0] klen, input int nr, input int stall);
    cipher_ctrl_pkg::add_rk_sel_e exp_sel;
    cipher_ctrl_pkg::sp2v_e       exp_we;
    int                           exp_rnd;
    accept_block(klen);
    for (int k = 1; k <= nr + 2; k++) begin
      @(negedge clk_i);
      in_valid_i = cipher_ctrl_pkg::SP2V_LOW;
      key_len_i  = cipher_ctrl_pkg::AES_192; // Sampled only at acceptance
      exp_we     = cipher_ctrl_pkg::SP2V_HIGH;
      if (k == 1) begin
        exp_sel = cipher_ctrl_pkg::ADD_RK_INIT;
        exp_rnd = 0;
      end else if (k <= nr) begin
        exp_sel = cipher_ctrl_pkg::ADD_RK_ROUND;
        exp_rnd = k - 1;
      end else if (k == nr + 1) begin
        exp_sel = cipher_ctrl_pkg::ADD_RK_FINAL;
        exp_rnd = nr;
      end else begin
        exp_sel = SEL_IDLE;   // Result waiting
        exp_rnd = nr;
        exp_we  = cipher_ctrl_pkg::SP2V_LOW;
      end
      check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("out_valid_o", out_valid_o, (k == nr + 2) ? cipher_ctrl_pkg::SP2V_HIGH
                                                         : cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("state_we_o", state_we_o, exp_we);
      check_sp2v("key_expand_en_o", key_expand_en_o, exp_we);
      check_sel("add_rk_sel_o", add_rk_sel_o, exp_sel);
      check_rnd("key_expand_round_o", key_expand_round_o, RND_W'(exp_rnd));
      check_bit("alert_o", alert_o, 1'b0);
    end
    // Back-pressure
    for (int s = 0; s < stall; s++) begin
      @(negedge clk_i);
      check_sp2v("out_valid_o", out_valid_o, cipher_ctrl_pkg::SP2V_HIGH);
      check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_LOW);
      check_rnd("key_expand_round_o", key_expand_round_o, RND_W'(nr));
    end
    out_ready_i = cipher_ctrl_pkg::SP2V_HIGH;
    @(negedge clk_i);
    out_ready_i = cipher_ctrl_pkg::SP2V_LOW;
    expect_idle();
  endtask

  task automatic hold_error(input int n);
    in_valid_i  = cipher_ctrl_pkg::SP2V_HIGH;  // Legal traffic must not revive it
    out_ready_i = cipher_ctrl_pkg::SP2V_HIGH;
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      check_bit("alert_o", alert_o, 1'b1);
      check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("out_valid_o", out_valid_o, cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("state_we_o", state_we_o, cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("key_expand_en_o", key_expand_en_o, cipher_ctrl_pkg::SP2V_LOW);
    end
    in_valid_i  = cipher_ctrl_pkg::SP2V_LOW;
    out_ready_i = cipher_ctrl_pkg::SP2V_LOW;
    apply_reset();
  endtask

  task automatic run_bad_sparse(input logic [2:0] bad_word);
    check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_HIGH);
    in_valid_i = cipher_ctrl_pkg::sp2v_e'(bad_word);
    @(negedge clk_i);
    check_bit("alert_o", alert_o, 1'b1);
    check_sp2v("in_ready_o", in_ready_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sp2v("out_valid_o", out_valid_o, cipher_ctrl_pkg::SP2V_LOW);
    hold_error(HOLD_CYCLES);
  endtask

  task automatic run_fatal(input logic [2:0] klen, input int nr);
    accept_block(klen);
    for (int k = 1; k <= FATAL_AT; k++) begin
      @(negedge clk_i);
      in_valid_i = cipher_ctrl_pkg::SP2V_LOW;
      check_sp2v("state_we_o", state_we_o, cipher_ctrl_pkg::SP2V_HIGH);
    end
    alert_fatal_i = 1'b1;
    @(negedge clk_i);
    alert_fatal_i = 1'b0;
    check_bit("alert_o", alert_o, 1'b1);
    hold_error(nr + 2);       // Covers the cycle the result would have shown up
  endtask

  task automatic run_bad_key(input logic [2:0] klen);
    accept_block(klen);
    @(negedge clk_i);
    in_valid_i = cipher_ctrl_pkg::SP2V_LOW;
    key_len_i  = cipher_ctrl_pkg::AES_128;
    check_bit("alert_o", alert_o, 1'b1);
    check_sp2v("state_we_o", state_we_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sp2v("key_expand_en_o", key_expand_en_o, cipher_ctrl_pkg::SP2V_LOW);
    check_sel("add_rk_sel_o", add_rk_sel_o, SEL_IDLE);
    check_rnd("key_expand_round_o", key_expand_round_o, '0);
    hold_error(HOLD_CYCLES);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table and main sequence
  //////////////////////////////////////////////////////////////////////

  task automatic load_table();
    tbl[0] = '{T_NORMAL, 3'b001, 0, 3'b000, 10};
    tbl[1] = '{T_NORMAL, 3'b010, 0, 3'b000, 12};
    tbl[2] = '{T_NORMAL, 3'b100, 0, 3'b000, 14};
    tbl[3] = '{T_NORMAL, 3'b001, 0, 3'b000, 10};
    tbl[4] = '{T_BAD_SP, 3'b001, 0, 3'b000, 0};
    tbl[5] = '{T_FATAL,  3'b100, 0, 3'b000, 14};
    tbl[6] = '{T_BAD_KL, 3'b011, 0, 3'b000, 0};
    tbl[7] = '{T_NORMAL, 3'b010, 0, 3'b000, 12};
    seed = 32'hbe91_e8e9;
    for (int r = 0; r < NUM_ROWS; r++) begin
      tbl[r].stall = 1 + ($unsigned($random(seed)) % MAX_STALL);
    end
  endtask

  function automatic string kind_name(input int kind);
    case (kind)
      T_NORMAL: return "round sequence";
      T_BAD_SP: return "illegal sparse input";
      T_FATAL:  return "fatal alert";
      default:  return "illegal key length";
    endcase
  endfunction

  initial begin
    rst_ni         = 1'b0;
    in_valid_i     = cipher_ctrl_pkg::SP2V_LOW;
    out_ready_i    = cipher_ctrl_pkg::SP2V_LOW;
    key_len_i      = cipher_ctrl_pkg::AES_128;
    alert_fatal_i  = 1'b0;
    n_checks       = 0;
    n_errors       = 0;
    n_failed_tests = 0;
    cycle_cnt      = 0;
    load_table();
    @(negedge clk_i);
    apply_reset();

    for (int r = 0; r < NUM_ROWS; r++) begin
      test_errors = 0;
      case (tbl[r].kind)
        T_NORMAL: run_rounds(tbl[r].key_len, tbl[r].nr, tbl[r].stall);
        T_BAD_SP: run_bad_sparse(tbl[r].bad_word);
        T_FATAL:  run_fatal(tbl[r].key_len, tbl[r].nr);
        default:  run_bad_key(tbl[r].key_len);
      endcase
      if (test_errors != 0) begin
        n_failed_tests++;
      end
      $display("Test %0d (%s, stall %0d): %0d mismatches", r, kind_name(tbl[r].kind),
               tbl[r].stall, test_errors);
    end

    $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
             NUM_ROWS, n_failed_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/cipher_ctrl_pkg.sv
logic/sp2v_buf_chk.sv
logic/cipher_ctrl_rail.sv
logic/rail_combine.sv
logic/cipher_ctrl.sv
testbench/cipher_ctrl_tb.sv
